// ==== rtl/swarm_core_pkg.sv ====
package swarm_core_pkg;

   // Task field widths
   localparam int TS_W     = 32;
   localparam int LOCALE_W = 16;
   localparam int TTYPE_W  = 4;
   localparam int ARGS_W   = 32;

   localparam int CQ_SLOT_W  = 7;
   localparam int CHILD_ID_W = 4;
   localparam int UNDO_ID_W  = 4;

   typedef logic [TS_W-1:0]     ts_t;
   typedef logic [LOCALE_W-1:0] locale_t;
   typedef logic [TTYPE_W-1:0]  ttype_t;
   typedef logic [ARGS_W-1:0]   args_t;

   // 84-bit task descriptor as exchanged with the CQ
   typedef struct packed {
      ts_t     ts;
      locale_t locale;
      ttype_t  ttype;
      args_t   args;
   } task_t;

   // Slot of the running task within the CQ slice
   typedef logic [CQ_SLOT_W-1:0] cq_slot_t;

   // Tied children enqueued by one task
   typedef logic [CHILD_ID_W-1:0] child_id_t;

   // Undo record index, restarts at 0 for each task
   typedef logic [UNDO_ID_W-1:0] undo_id_t;

   // One undo log entry, old data at a memory address
   typedef struct packed {
      logic [31:0] addr;
      logic [31:0] data;
   } undo_rec_t;

endpackage

// ==== rtl/task_sequencer.sv ====
`timescale 1ns/10ps

module task_sequencer #(
   parameter int TASK_TYPE  = 0,
   parameter int ABORT_HOLD = 6
) (
   input  logic                     clk,
   input  logic                     rstn,
   input  logic                     enable,
   output logic                     task_arvalid,
   output swarm_core_pkg::ttype_t   task_araddr,
   input  logic                     task_rvalid,
   input  swarm_core_pkg::task_t    task_rdata,
   input  swarm_core_pkg::cq_slot_t task_rslot,
   output logic                     start_task_valid,
   input  logic                     start_task_ready,
   output logic                     finish_task_valid,
   input  logic                     finish_task_ready,
   input  logic                     abort_running_task,
   input  swarm_core_pkg::cq_slot_t abort_running_slot,
   output logic                     app_start,
   output swarm_core_pkg::task_t    app_task,
   output logic                     app_rstn,
   input  logic                     app_done,
   output logic                     new_task,
   output swarm_core_pkg::cq_slot_t cq_slot,
   output logic                     aborting,
   input  logic                     drained
);
   import swarm_core_pkg::*;

   localparam int HOLD_W = $clog2(ABORT_HOLD + 1);

   typedef enum logic [2:0] {
      NEXT_TASK,
      INFORM_CQ,
      START_APP,
      WAIT_APP,
      ABORT_APP,
      FINISH_TASK
   } core_state_t;

   core_state_t       state;
   core_state_t       state_next;
   logic              dequeue;
   logic              abort_q;
   logic              abort_hit;
   logic              abort_now;
   logic [HOLD_W-1:0] hold_cnt;
   logic              hold_done;

   // app_rstn is low out of reset, which also keeps the dequeue request quiet
   assign task_araddr       = ttype_t'(TASK_TYPE);
   assign task_arvalid      = (state == NEXT_TASK) & enable & app_rstn;
   assign dequeue           = task_arvalid & task_rvalid;
   assign new_task          = dequeue;
   assign start_task_valid  = (state == INFORM_CQ);
   assign finish_task_valid = (state == FINISH_TASK) & drained;
   assign aborting          = (state == ABORT_APP);

   // Only aborts aimed at our slot count, and only while a task is held
   assign abort_hit = abort_running_task & (abort_running_slot == cq_slot) &
                      (state != NEXT_TASK) & (state != ABORT_APP);
   assign abort_now = abort_q | abort_hit;

   assign app_start = (state == START_APP) & ~abort_now;
   assign hold_done = (hold_cnt == HOLD_W'(ABORT_HOLD - 1));

   always_ff @(posedge clk) begin
      if (dequeue) begin
         app_task <= task_rdata;
         cq_slot  <= task_rslot;
      end
   end

   always_comb begin
      state_next = state;
      case (state)
         NEXT_TASK: begin
            if (dequeue) begin
               state_next = INFORM_CQ;
            end
         end
         INFORM_CQ: begin
            if (start_task_ready) begin
               state_next = abort_now ? ABORT_APP : START_APP;
            end
         end
         START_APP: begin
            state_next = abort_now ? ABORT_APP : WAIT_APP;
         end
         WAIT_APP: begin
            if (abort_now) begin
               state_next = ABORT_APP;
            end else if (app_done) begin
               state_next = FINISH_TASK;
            end
         end
         ABORT_APP: begin
            if (hold_done) begin
               state_next = FINISH_TASK;
            end
         end
         FINISH_TASK: begin
            // Once finish is offered it stays offered, a late abort rides along
            if (finish_task_valid & finish_task_ready) begin
               state_next = NEXT_TASK;
            end else if (abort_now & ~finish_task_valid) begin
               state_next = ABORT_APP;
            end
         end
         default: begin
            state_next = NEXT_TASK;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state    <= NEXT_TASK;
         abort_q  <= 1'b0;
         hold_cnt <= '0;
         app_rstn <= 1'b0;
      end else begin
         state    <= state_next;
         app_rstn <= (state_next != ABORT_APP);
         if ((state == NEXT_TASK) || (state == ABORT_APP)) begin
            abort_q <= 1'b0;
         end else if (abort_hit) begin
            abort_q <= 1'b1;
         end
         if (state == ABORT_APP) begin
            hold_cnt <= hold_cnt + 1'b1;
         end else begin
            hold_cnt <= '0;
         end
      end
   end

endmodule

// ==== rtl/child_task_unit.sv ====
`timescale 1ns/10ps

module child_task_unit (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      app_rstn,
   input  logic                      app_start,
   input  swarm_core_pkg::task_t     app_task,
   output logic                      child_valid,
   input  logic                      child_ready,
   output swarm_core_pkg::task_t     child_task,
   output logic                      undo_valid,
   input  logic                      undo_ready,
   output swarm_core_pkg::undo_rec_t undo_rec,
   output logic                      app_done
);
   import swarm_core_pkg::*;

   typedef enum logic [2:0] {
      IDLE,
      EMIT,
      GAP,
      UNDO,
      DONE
   } app_state_t;

   app_state_t  state;
   task_t       parent;
   logic [1:0]  child_k;
   logic [3:0]  gap_cnt;

   assign child_valid = (state == EMIT);
   assign undo_valid  = (state == UNDO);
   assign app_done    = (state == DONE);

   // Child k of the parent
   always_comb begin
      child_task.ts     = parent.ts + ts_t'(child_k) + ts_t'(1);
      child_task.locale = parent.locale + locale_t'(child_k);
      child_task.ttype  = parent.ttype;
      child_task.args   = parent.args >> 2;
   end

   assign undo_rec.addr = 32'(parent.locale);
   assign undo_rec.data = parent.ts;

   always_ff @(posedge clk) begin
      if (app_start) begin
         parent <= app_task;
      end
   end

   // An abort holds app_rstn low and drops the unit back to idle
   always_ff @(posedge clk) begin
      if (!rstn || !app_rstn) begin
         state   <= IDLE;
         child_k <= '0;
         gap_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (app_start) begin
                  child_k <= '0;
                  gap_cnt <= app_task.args[7:4];
                  state   <= (app_task.args[1:0] != 2'd0) ? EMIT : GAP;
               end
            end
            EMIT: begin
               if (child_ready) begin
                  child_k <= child_k + 1'b1;
                  if (child_k == parent.args[1:0] - 2'd1) begin
                     state <= GAP;
                  end
               end
            end
            GAP: begin
               if (gap_cnt == 4'd0) begin
                  state <= parent.args[2] ? UNDO : DONE;
               end else begin
                  gap_cnt <= gap_cnt - 1'b1;
               end
            end
            UNDO: begin
               if (undo_ready) begin
                  state <= DONE;
               end
            end
            DONE: begin
               state <= IDLE;
            end
            default: begin
               state <= IDLE;
            end
         endcase
      end
   end

endmodule

// ==== rtl/core_output_stage.sv ====
`timescale 1ns/10ps

module core_output_stage (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      new_task,
   input  logic                      aborting,
   input  swarm_core_pkg::cq_slot_t  cq_slot,
   input  logic                      gvt_task_slot_valid,
   input  swarm_core_pkg::cq_slot_t  gvt_task_slot,
   input  logic                      child_valid,
   output logic                      child_ready,
   input  swarm_core_pkg::task_t     child_task,
   input  logic                      undo_valid,
   output logic                      undo_ready,
   input  swarm_core_pkg::undo_rec_t undo_rec,
   output logic                      task_wvalid,
   output swarm_core_pkg::task_t     task_wdata,
   input  logic                      task_wready,
   output logic                      task_enq_untied,
   output swarm_core_pkg::cq_slot_t  task_cq_slot,
   output swarm_core_pkg::child_id_t task_child_id,
   output logic                      undo_log_valid,
   input  logic                      undo_log_ready,
   output swarm_core_pkg::undo_id_t  undo_log_id,
   output swarm_core_pkg::undo_rec_t undo_log_rec,
   output swarm_core_pkg::cq_slot_t  undo_log_slot,
   output swarm_core_pkg::cq_slot_t  finish_task_slot,
   output swarm_core_pkg::child_id_t finish_task_num_children,
   output logic                      finish_task_undo_log_write,
   output logic                      drained
);

   logic gvt_match_q;
   logic enq_fire;
   logic undo_fire;

   // One-entry registers, ready only while empty
   assign child_ready = ~task_wvalid;
   assign undo_ready  = ~undo_log_valid;
   assign enq_fire    = task_wvalid & task_wready;
   assign undo_fire   = undo_log_valid & undo_log_ready;
   assign drained     = ~task_wvalid & ~undo_log_valid;

   // The GVT task cannot be rolled back, so its children go out untied
   assign task_enq_untied = gvt_match_q;

   assign task_cq_slot             = cq_slot;
   assign undo_log_slot            = cq_slot;
   assign finish_task_slot         = cq_slot;
   assign finish_task_num_children = task_child_id;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         task_wvalid <= 1'b0;
      end else if (aborting) begin
         task_wvalid <= 1'b0;
      end else if (child_valid & child_ready) begin
         task_wvalid <= 1'b1;
      end else if (task_wready) begin
         task_wvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (child_valid & child_ready) begin
         task_wdata <= child_task;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         undo_log_valid <= 1'b0;
      end else if (aborting) begin
         undo_log_valid <= 1'b0;
      end else if (undo_valid & undo_ready) begin
         undo_log_valid <= 1'b1;
      end else if (undo_log_ready) begin
         undo_log_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (undo_valid & undo_ready) begin
         undo_log_rec <= undo_rec;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         gvt_match_q                <= 1'b0;
         task_child_id              <= '0;
         undo_log_id                <= '0;
         finish_task_undo_log_write <= 1'b0;
      end else begin
         gvt_match_q <= gvt_task_slot_valid & (gvt_task_slot == cq_slot);
         if (new_task) begin
            task_child_id              <= '0;
            undo_log_id                <= '0;
            finish_task_undo_log_write <= 1'b0;
         end else begin
            // untied children get no cut-tie message, so they are not counted
            if (enq_fire & ~gvt_match_q) begin
               task_child_id <= task_child_id + 1'b1;
            end
            if (undo_fire) begin
               undo_log_id                <= undo_log_id + 1'b1;
               finish_task_undo_log_write <= 1'b1;
            end
         end
      end
   end

endmodule

// ==== rtl/task_core.sv ====
`timescale 1ns/10ps

module task_core #(
   parameter int TASK_TYPE  = 0,
   parameter int ABORT_HOLD = 6
) (
   input  logic                      clk,
   input  logic                      rstn,
   input  logic                      enable,

   // Dequeue
   output logic                      task_arvalid,
   output swarm_core_pkg::ttype_t    task_araddr,
   input  logic                      task_rvalid,
   input  swarm_core_pkg::task_t     task_rdata,
   input  swarm_core_pkg::cq_slot_t  task_rslot,

   // Enqueue
   output logic                      task_wvalid,
   output swarm_core_pkg::task_t     task_wdata,
   input  logic                      task_wready,
   output logic                      task_enq_untied,
   output swarm_core_pkg::cq_slot_t  task_cq_slot,
   output swarm_core_pkg::child_id_t task_child_id,

   // Start and finish reports to the CQ
   output logic                      start_task_valid,
   input  logic                      start_task_ready,
   output swarm_core_pkg::cq_slot_t  start_task_slot,
   output logic                      finish_task_valid,
   input  logic                      finish_task_ready,
   output swarm_core_pkg::cq_slot_t  finish_task_slot,
   output swarm_core_pkg::child_id_t finish_task_num_children,
   output logic                      finish_task_undo_log_write,

   input  logic                      abort_running_task,
   input  swarm_core_pkg::cq_slot_t  abort_running_slot,
   input  logic                      gvt_task_slot_valid,
   input  swarm_core_pkg::cq_slot_t  gvt_task_slot,

   // Undo log
   output logic                      undo_log_valid,
   input  logic                      undo_log_ready,
   output swarm_core_pkg::undo_id_t  undo_log_id,
   output swarm_core_pkg::undo_rec_t undo_log_rec,
   output swarm_core_pkg::cq_slot_t  undo_log_slot
);
   import swarm_core_pkg::*;

   logic      app_start;
   task_t     app_task;
   logic      app_rstn;
   logic      app_done;
   logic      new_task;
   cq_slot_t  cq_slot;
   logic      aborting;
   logic      drained;
   logic      child_valid;
   logic      child_ready;
   task_t     child_task;
   logic      undo_valid;
   logic      undo_ready;
   undo_rec_t undo_rec;

   assign start_task_slot = cq_slot;

   task_sequencer #(
      .TASK_TYPE  (TASK_TYPE),
      .ABORT_HOLD (ABORT_HOLD)
   ) u_sequencer (
      .clk                (clk),
      .rstn               (rstn),
      .enable             (enable),
      .task_arvalid       (task_arvalid),
      .task_araddr        (task_araddr),
      .task_rvalid        (task_rvalid),
      .task_rdata         (task_rdata),
      .task_rslot         (task_rslot),
      .start_task_valid   (start_task_valid),
      .start_task_ready   (start_task_ready),
      .finish_task_valid  (finish_task_valid),
      .finish_task_ready  (finish_task_ready),
      .abort_running_task (abort_running_task),
      .abort_running_slot (abort_running_slot),
      .app_start          (app_start),
      .app_task           (app_task),
      .app_rstn           (app_rstn),
      .app_done           (app_done),
      .new_task           (new_task),
      .cq_slot            (cq_slot),
      .aborting           (aborting),
      .drained            (drained)
   );

   child_task_unit u_app (
      .clk         (clk),
      .rstn        (rstn),
      .app_rstn    (app_rstn),
      .app_start   (app_start),
      .app_task    (app_task),
      .child_valid (child_valid),
      .child_ready (child_ready),
      .child_task  (child_task),
      .undo_valid  (undo_valid),
      .undo_ready  (undo_ready),
      .undo_rec    (undo_rec),
      .app_done    (app_done)
   );

   core_output_stage u_out (
      .clk                        (clk),
      .rstn                       (rstn),
      .new_task                   (new_task),
      .aborting                   (aborting),
      .cq_slot                    (cq_slot),
      .gvt_task_slot_valid        (gvt_task_slot_valid),
      .gvt_task_slot              (gvt_task_slot),
      .child_valid                (child_valid),
      .child_ready                (child_ready),
      .child_task                 (child_task),
      .undo_valid                 (undo_valid),
      .undo_ready                 (undo_ready),
      .undo_rec                   (undo_rec),
      .task_wvalid                (task_wvalid),
      .task_wdata                 (task_wdata),
      .task_wready                (task_wready),
      .task_enq_untied            (task_enq_untied),
      .task_cq_slot               (task_cq_slot),
      .task_child_id              (task_child_id),
      .undo_log_valid             (undo_log_valid),
      .undo_log_ready             (undo_log_ready),
      .undo_log_id                (undo_log_id),
      .undo_log_rec               (undo_log_rec),
      .undo_log_slot              (undo_log_slot),
      .finish_task_slot           (finish_task_slot),
      .finish_task_num_children   (finish_task_num_children),
      .finish_task_undo_log_write (finish_task_undo_log_write),
      .drained                    (drained)
   );

endmodule

// ==== test/task_core_chk.sv ====
`timescale 1ns/10ps

module task_core_chk (
   input logic                      clk,
   input logic                      rstn,
   input logic                      aborting,
   input logic                      task_arvalid,
   input logic                      task_wvalid,
   input logic                      task_wready,
   input swarm_core_pkg::task_t     task_wdata,
   input logic                      undo_log_valid,
   input logic                      undo_log_ready,
   input swarm_core_pkg::undo_rec_t undo_log_rec,
   input logic                      start_task_valid,
   input logic                      start_task_ready,
   input logic                      finish_task_valid,
   input logic                      finish_task_ready
);

   int   fail_cnt = 0;
   logic in_reset_q;

   always_ff @(posedge clk) begin
      in_reset_q <= !rstn;
   end

   // An abort may drop a pending enqueue or undo record
   enq_hold: assert property (@(posedge clk) disable iff (!rstn)
      task_wvalid && !task_wready && !aborting |=> task_wvalid && $stable(task_wdata))
      else begin
         fail_cnt++;
         $error("enqueue changed or dropped before task_wready");
      end

   undo_hold: assert property (@(posedge clk) disable iff (!rstn)
      undo_log_valid && !undo_log_ready && !aborting |=>
         undo_log_valid && $stable(undo_log_rec))
      else begin
         fail_cnt++;
         $error("undo record changed or dropped before undo_log_ready");
      end

   start_hold: assert property (@(posedge clk) disable iff (!rstn)
      start_task_valid && !start_task_ready |=> start_task_valid)
      else begin
         fail_cnt++;
         $error("start_task_valid fell before start_task_ready");
      end

   finish_hold: assert property (@(posedge clk) disable iff (!rstn)
      finish_task_valid && !finish_task_ready |=> finish_task_valid)
      else begin
         fail_cnt++;
         $error("finish_task_valid fell before finish_task_ready");
      end

   start_finish_apart: assert property (@(posedge clk) disable iff (!rstn)
      !(start_task_valid && finish_task_valid))
      else begin
         fail_cnt++;
         $error("start and finish offered in the same cycle");
      end

   reset_quiet: assert property (@(posedge clk)
      in_reset_q && !rstn |-> !(task_arvalid || start_task_valid || finish_task_valid ||
                                task_wvalid || undo_log_valid))
      else begin
         fail_cnt++;
         $error("output valid high during reset");
      end

endmodule

// ==== test/task_core_tb.sv ====
`timescale 1ns/10ps

module task_core_tb;
   import swarm_core_pkg::*;

   localparam int NUM_TASKS = 40;
   localparam int TIMEOUT   = 200 * NUM_TASKS;
   localparam int TAIL      = 20;

   typedef enum logic [1:0] {
      IDLE,
      DEQUEUED,
      STARTED
   } phase_t;

   logic      clk;
   logic      rstn;
   logic      enable;
   logic      task_arvalid;
   ttype_t    task_araddr;
   logic      task_rvalid;
   task_t     task_rdata;
   cq_slot_t  task_rslot;
   logic      task_wvalid;
   task_t     task_wdata;
   logic      task_wready;
   logic      task_enq_untied;
   cq_slot_t  task_cq_slot;
   child_id_t task_child_id;
   logic      start_task_valid;
   logic      start_task_ready;
   cq_slot_t  start_task_slot;
   logic      finish_task_valid;
   logic      finish_task_ready;
   cq_slot_t  finish_task_slot;
   child_id_t finish_task_num_children;
   logic      finish_task_undo_log_write;
   logic      abort_running_task;
   cq_slot_t  abort_running_slot;
   logic      gvt_task_slot_valid;
   cq_slot_t  gvt_task_slot;
   logic      undo_log_valid;
   logic      undo_log_ready;
   undo_id_t  undo_log_id;
   undo_rec_t undo_log_rec;
   cq_slot_t  undo_log_slot;

   // Reference model of the running task
   logic [31:0] lfsr;
   phase_t      phase;
   task_t       parent;
   cq_slot_t    run_slot;
   task_t       child_q[$];
   logic        undo_exp;
   logic        undo_seen;
   logic        aborted;
   logic        untied_exp;
   int          tied_cnt;
   int          deq_cnt;
   int          fin_cnt;
   int          abort_cnt;

   task_core #(
      .TASK_TYPE  (0),
      .ABORT_HOLD (6)
   ) uut (.*);

   bind task_core task_core_chk u_chk (.*);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_take(input int n);
      logic [31:0] bits;
      logic        fb;
      bits = '0;
      repeat (n) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         bits = {bits[30:0], fb};
      end
      return bits;
   endfunction

   function automatic task_t predict_child(input task_t p, input int k);
      task_t c;
      c.ts     = p.ts + ts_t'(k + 1);
      c.locale = p.locale + locale_t'(k);
      c.ttype  = p.ttype;
      c.args   = p.args >> 2;
      return c;
   endfunction

   task automatic report_failure(input string why);
      $display("%s", why);
      $display("*** TEST FAILED ***");
      $fatal(1, "Run stopped at the first failure");
   endtask

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         report_failure($sformatf("** Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
      end
   endtask

   task automatic sample_and_check();
      logic  match_now;
      task_t exp_child;
      int    k;
      match_now = gvt_task_slot_valid && (gvt_task_slot == run_slot);
      if (uut.u_chk.fail_cnt != 0) begin
         report_failure("A CQ port assertion in the bound checker failed");
      end
      if (abort_running_task && (phase != IDLE) && (abort_running_slot == run_slot)) begin
         aborted = 1'b1;
      end
      if (!enable) begin
         check_value("task_arvalid", task_arvalid, 0);
      end
      if (task_arvalid) begin
         check_value("task_araddr", task_araddr, 0);
      end
      if (task_arvalid && task_rvalid) begin
         if (phase != IDLE) begin
            report_failure("Dequeue while the previous task was still running");
         end
         parent   = task_rdata;
         run_slot = task_rslot;
         child_q.delete();
         for (k = 0; k < task_rdata.args[1:0]; k++) begin
            child_q.push_back(predict_child(task_rdata, k));
         end
         undo_exp  = task_rdata.args[2];
         undo_seen = 1'b0;
         aborted   = 1'b0;
         tied_cnt  = 0;
         phase     = DEQUEUED;
         deq_cnt++;
      end
      if (start_task_valid && start_task_ready) begin
         if (phase != DEQUEUED) begin
            report_failure("Start report without a dequeued task");
         end
         check_value("start_task_slot", start_task_slot, run_slot);
         phase = STARTED;
      end
      if (task_wvalid && task_wready) begin
         if (phase != STARTED) begin
            report_failure("Enqueue outside a running task");
         end
         if (child_q.size() == 0) begin
            report_failure("Enqueue beyond the predicted children of the task");
         end
         exp_child = child_q.pop_front();
         check_value("task_wdata", task_wdata, exp_child);
         check_value("task_cq_slot", task_cq_slot, run_slot);
         check_value("task_enq_untied", task_enq_untied, untied_exp);
         check_value("task_child_id", task_child_id, tied_cnt);
         if (!untied_exp) begin
            tied_cnt++;
         end
      end
      if (undo_log_valid && undo_log_ready) begin
         if (phase != STARTED) begin
            report_failure("Undo record outside a running task");
         end
         if (!undo_exp || undo_seen) begin
            report_failure("Undo record from a task that should not write one");
         end
         check_value("undo_log_rec.addr", undo_log_rec.addr, {16'h0, parent.locale});
         check_value("undo_log_rec.data", undo_log_rec.data, parent.ts);
         check_value("undo_log_id", undo_log_id, 0);
         check_value("undo_log_slot", undo_log_slot, run_slot);
         undo_seen = 1'b1;
      end
      if (finish_task_valid && finish_task_ready) begin
         if (phase != STARTED) begin
            report_failure("Finish report without a started task");
         end
         check_value("finish_task_slot", finish_task_slot, run_slot);
         check_value("finish_task_num_children", finish_task_num_children, tied_cnt);
         check_value("finish_task_undo_log_write", finish_task_undo_log_write, undo_seen);
         // Without an abort the task must have run to the end
         if (!aborted) begin
            check_value("children not enqueued", child_q.size(), 0);
            check_value("undo record written", undo_seen, undo_exp);
         end else begin
            abort_cnt++;
         end
         child_q.delete();
         phase = IDLE;
         fin_cnt++;
      end
      untied_exp = match_now;
   endtask

   task automatic drive_inputs();
      task_t t;
      t.ts     = ts_t'(lfsr_take(32));
      t.locale = locale_t'(lfsr_take(16));
      t.ttype  = ttype_t'(lfsr_take(4));
      t.args   = args_t'(lfsr_take(32));
      task_rdata          <= t;
      task_rslot          <= cq_slot_t'(lfsr_take(7));
      task_rvalid         <= (lfsr_take(1) != 32'd0);
      start_task_ready    <= (lfsr_take(2) != 32'd0);
      finish_task_ready   <= (lfsr_take(2) != 32'd0);
      task_wready         <= (lfsr_take(2) != 32'd0);
      undo_log_ready      <= (lfsr_take(1) != 32'd0);
      gvt_task_slot_valid <= (lfsr_take(1) != 32'd0);
      gvt_task_slot       <= (lfsr_take(2) == 32'd0) ? run_slot : cq_slot_t'(lfsr_take(7));
      abort_running_task  <= (lfsr_take(6) == 32'd0);
      abort_running_slot  <= (lfsr_take(1) != 32'd0) ? run_slot : (run_slot ^ cq_slot_t'(1));
      if (deq_cnt >= NUM_TASKS) begin
         enable <= 1'b0;
      end
   endtask

   initial begin
      int cycles;
      int tail;
      lfsr       = 32'hcd7c21cc;
      phase      = IDLE;
      parent     = '0;
      run_slot   = '0;
      undo_exp   = 1'b0;
      undo_seen  = 1'b0;
      aborted    = 1'b0;
      untied_exp = 1'b0;
      tied_cnt   = 0;
      deq_cnt    = 0;
      fin_cnt    = 0;
      abort_cnt  = 0;
      cycles     = 0;
      tail       = 0;
      rstn                <= 1'b0;
      enable              <= 1'b0;
      task_rvalid         <= 1'b0;
      task_rdata          <= '0;
      task_rslot          <= '0;
      task_wready         <= 1'b0;
      start_task_ready    <= 1'b0;
      finish_task_ready   <= 1'b0;
      abort_running_task  <= 1'b0;
      abort_running_slot  <= '0;
      gvt_task_slot_valid <= 1'b0;
      gvt_task_slot       <= '0;
      undo_log_ready      <= 1'b0;
      repeat (10) @(posedge clk);
      rstn   <= 1'b1;
      enable <= 1'b1;
      while (tail < TAIL) begin
         @(posedge clk);
         sample_and_check();
         drive_inputs();
         cycles++;
         if (fin_cnt == NUM_TASKS) begin
            tail++;
         end
         if (cycles >= TIMEOUT) begin
            report_failure($sformatf("Timeout after %0d cycles with %0d of %0d tasks finished",
                                     cycles, fin_cnt, NUM_TASKS));
         end
      end
      $display("%0d tasks finished, %0d of them aborted", fin_cnt, abort_cnt);
      @(negedge clk);
      if (uut.u_chk.fail_cnt == 0) begin
         $display("*** TEST PASSED ***");
         $finish;
      end else begin
         report_failure("A CQ port assertion in the bound checker failed");
      end
   end

endmodule

// ==== task_core.f ====
rtl/swarm_core_pkg.sv
rtl/task_sequencer.sv
rtl/child_task_unit.sv
rtl/core_output_stage.sv
rtl/task_core.sv
test/task_core_chk.sv
test/task_core_tb.sv

// ==== Bender.yml ====
package:
  name: task_core

sources:
  - rtl/swarm_core_pkg.sv
  - rtl/task_sequencer.sv
  - rtl/child_task_unit.sv
  - rtl/core_output_stage.sv
  - rtl/task_core.sv
  - target: test
    files:
      - test/task_core_chk.sv
      - test/task_core_tb.sv
